// ==== files.f ====
src/lsu_pkg.sv
src/dbus_if.sv
src/mem_unit.sv
src/dmmu_check.sv
src/data_ram.sv
src/lsu_top.sv
verification/tb_lsu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module tb_lsu -o tb_lsu --Mdir obj_dir
	./obj_dir/tb_lsu > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q '\*\*\* FAILED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_lsu.sv ====
// Load/store path testbench

`timescale 1ns/1ps

module tb_lsu;

   // Longest wb_ready stall and the op count the watchdog allows for
   localparam int max_stall     = 8;
   localparam int op_budget     = 128;
   localparam int cycles_per_op = max_stall + 10;

   logic                         clk;
   logic                         reset;
   logic                         in_valid;
   logic                         in_ready;
   logic [31:0]                  operand_1;
   logic [31:0]                  operand_2;
   logic [31:0]                  operand_3;
   lsu_pkg::lsu_op_e             op;
   logic                         sign_ext;
   lsu_pkg::access_size_e        size;
   logic [31:0]                  load_data;
   logic                         exp_taken;
   logic [29:0]                  exp_tgt;
   logic [31:0]                  lsa;
   logic                         wb_valid;
   logic                         wb_ready;

   logic [31:0] seed = 32'hfac2;
   // Expected RAM contents with one entry per byte
   logic [7:0]  shadow [0:4095];
   int          errors = 0;
   int          checks = 0;

   lsu_top UUT (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .operand_1 (operand_1),
      .operand_2 (operand_2),
      .operand_3 (operand_3),
      .op        (op),
      .sign_ext  (sign_ext),
      .size      (size),
      .load_data (load_data),
      .exp_taken (exp_taken),
      .exp_tgt   (exp_tgt),
      .lsa       (lsa),
      .wb_valid  (wb_valid),
      .wb_ready  (wb_ready)
   );

   always #5 clk = ~clk;

   function logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Word-aligned address in 0x100..0xFFC
   function automatic logic [31:0] rand_addr();
      return (32'h100 + (lcg_next() >> 8) % 32'hf00) & ~32'h3;
   endfunction

   function automatic int rand_stall();
      return 1 + int'((lcg_next() >> 16) % max_stall);
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("** Error at %0t: %s = 0x%08h, expected 0x%08h",
                  $time, name, actual, expected);
      end
   endtask

   // Addressed bytes from the shadow with zero or sign extension
   function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                               input lsu_pkg::access_size_e s,
                                               input logic sx);
      int          i;
      logic [7:0]  b;
      logic [15:0] h;
      i = int'(addr[11:0]);
      b = shadow[i];
      h = {shadow[i+1], shadow[i]};
      case (s)
         lsu_pkg::size_byte: return {{24{sx & b[7]}}, b};
         lsu_pkg::size_half: return {{16{sx & h[15]}}, h};
         default:            return {shadow[i+3], shadow[i+2], h};
      endcase
   endfunction

   // Low bytes of the store data land at the addressed bytes
   function automatic void shadow_write(input logic [31:0] addr,
                                        input lsu_pkg::access_size_e s,
                                        input logic [31:0] data);
      int n;
      n = (s == lsu_pkg::size_byte) ? 1 : (s == lsu_pkg::size_half) ? 2 : 4;
      for (int k = 0; k < n; k++) begin
         shadow[int'(addr[11:0]) + k] = data[8*k +: 8];
      end
   endfunction

   // One operation held until result or exception with optional wb stall
   task automatic run_op(input lsu_pkg::lsu_op_e o, input lsu_pkg::access_size_e s,
                         input logic sx, input logic [31:0] addr,
                         input logic [31:0] data, input int stall,
                         output logic [31:0] rdata, output logic took_exp,
                         output logic [29:0] tgt);
      logic [31:0] off;
      off      = lcg_next() >> 24;
      took_exp = 1'b0;
      rdata    = 'x;
      tgt      = '0;
      @(posedge clk);
      in_valid  <= 1'b1;
      op        <= o;
      size      <= s;
      sign_ext  <= sx;
      // Split the address over both operands
      operand_1 <= addr - off;
      operand_2 <= off;
      operand_3 <= data;
      wb_ready  <= (stall == 0);
      @(negedge clk);
      check("lsa", lsa, addr);
      while (!wb_valid && !exp_taken) @(negedge clk);
      if (exp_taken) begin
         took_exp = 1'b1;
         tgt      = exp_tgt;
         check("in_ready", in_ready, 1);
      end else begin
         rdata = load_data;
         // Result must hold still while writeback stalls
         for (int k = 0; k < stall; k++) begin
            if (k > 0) begin
               @(negedge clk);
               check("wb_valid", wb_valid, 1);
               check("load_data", load_data, rdata);
            end
            check("in_ready", in_ready, 0);
         end
         if (stall > 0) begin
            @(posedge clk);
            wb_ready <= 1'b1;
            @(negedge clk);
            check("wb_valid", wb_valid, 1);
            check("load_data", load_data, rdata);
         end
         check("in_ready", in_ready, 1);
      end
      @(posedge clk);
      in_valid <= 1'b0;
      op       <= lsu_pkg::op_none;
      wb_ready <= 1'b1;
      // Nothing may follow an exception
      if (took_exp) begin
         repeat (2) begin
            @(negedge clk);
            check("wb_valid", wb_valid, 0);
            check("exp_taken", exp_taken, 0);
         end
      end
   endtask

   task automatic do_store(input lsu_pkg::access_size_e s, input logic [31:0] addr,
                           input logic [31:0] data, input int stall);
      logic [31:0] rdata;
      logic        took;
      logic [29:0] tgt;
      run_op(lsu_pkg::op_store, s, 1'b0, addr, data, stall, rdata, took, tgt);
      check("exp_taken", took, 0);
      shadow_write(addr, s, data);
   endtask

   task automatic do_load(input lsu_pkg::access_size_e s, input logic sx,
                          input logic [31:0] addr, input int stall);
      logic [31:0] rdata;
      logic        took;
      logic [29:0] tgt;
      run_op(lsu_pkg::op_load, s, sx, addr, lcg_next(), stall, rdata, took, tgt);
      check("exp_taken", took, 0);
      check("load_data", rdata, expect_load(addr, s, sx));
   endtask

   // Expect an exception whose target is the vector without its low bits
   task automatic do_fault(input lsu_pkg::lsu_op_e o, input lsu_pkg::access_size_e s,
                           input logic [31:0] addr, input logic [7:0] vec);
      logic [31:0] rdata;
      logic        took;
      logic [29:0] tgt;
      run_op(o, s, 1'b0, addr, lcg_next(), 0, rdata, took, tgt);
      check("exp_taken", took, 1);
      check("exp_tgt", tgt, 32'(vec) >> 2);
   endtask

   task automatic test_word_roundtrip();
      logic [31:0] a;
      repeat (8) begin
         a = rand_addr();
         do_store(lsu_pkg::size_word, a, lcg_next(), 0);
         do_load(lsu_pkg::size_word, 1'b0, a, 0);
      end
   endtask

   task automatic test_subword();
      logic [31:0] a;
      repeat (2) begin
         a = rand_addr();
         do_store(lsu_pkg::size_word, a, lcg_next(), 0);
         for (int k = 0; k < 4; k++) begin
            do_store(lsu_pkg::size_byte, a + k, lcg_next(), 0);
            // Whole word shows that neighbour bytes kept their values
            do_load(lsu_pkg::size_word, 1'b0, a, 0);
            do_load(lsu_pkg::size_byte, 1'b0, a + k, 0);
            do_load(lsu_pkg::size_byte, 1'b1, a + k, 0);
         end
         for (int k = 0; k < 4; k += 2) begin
            do_store(lsu_pkg::size_half, a + k, lcg_next(), 0);
            do_load(lsu_pkg::size_word, 1'b0, a, 0);
            do_load(lsu_pkg::size_half, 1'b0, a + k, 0);
            do_load(lsu_pkg::size_half, 1'b1, a + k, 0);
         end
      end
   endtask

   task automatic test_misalign();
      logic [31:0] a;
      a = rand_addr();
      do_store(lsu_pkg::size_word, a, lcg_next(), 0);
      for (int k = 1; k < 4; k++) begin
         do_fault(lsu_pkg::op_store, lsu_pkg::size_word, a + k, lsu_pkg::ealign_vector);
         do_fault(lsu_pkg::op_load, lsu_pkg::size_word, a + k, lsu_pkg::ealign_vector);
      end
      do_fault(lsu_pkg::op_store, lsu_pkg::size_half, a + 1, lsu_pkg::ealign_vector);
      do_fault(lsu_pkg::op_store, lsu_pkg::size_half, a + 3, lsu_pkg::ealign_vector);
      do_fault(lsu_pkg::op_load, lsu_pkg::size_half, a + 1, lsu_pkg::ealign_vector);
      // Rejected stores left the word alone
      do_load(lsu_pkg::size_word, 1'b0, a, 0);
   endtask

   task automatic test_mmu_faults();
      do_fault(lsu_pkg::op_load, lsu_pkg::size_word, 32'h1000, lsu_pkg::edtm_vector);
      do_fault(lsu_pkg::op_store, lsu_pkg::size_word, 32'h1000 + rand_addr(),
               lsu_pkg::edtm_vector);
      do_fault(lsu_pkg::op_store, lsu_pkg::size_byte, 32'h0ff, lsu_pkg::edpf_vector);
      do_fault(lsu_pkg::op_store, lsu_pkg::size_word, rand_addr() & 32'hfc,
               lsu_pkg::edpf_vector);
   endtask

   task automatic test_stall();
      logic [31:0] a;
      repeat (6) begin
         a = rand_addr();
         do_store(lsu_pkg::size_word, a, lcg_next(), rand_stall());
         do_load(lsu_pkg::size_word, 1'b0, a, rand_stall());
         do_load(lsu_pkg::size_byte, 1'b1, a + (lcg_next() >> 30), rand_stall());
      end
   endtask

   task automatic test_no_op();
      @(posedge clk);
      in_valid <= 1'b1;
      op       <= lsu_pkg::op_none;
      @(negedge clk);
      check("in_ready", in_ready, 1);
      check("wb_valid", wb_valid, 0);
      check("exp_taken", exp_taken, 0);
      @(posedge clk);
      in_valid <= 1'b0;
      repeat (2) begin
         @(negedge clk);
         check("wb_valid", wb_valid, 0);
         check("exp_taken", exp_taken, 0);
      end
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      in_valid  = 1'b0;
      op        = lsu_pkg::op_none;
      size      = lsu_pkg::size_word;
      sign_ext  = 1'b0;
      operand_1 = '0;
      operand_2 = '0;
      operand_3 = '0;
      wb_ready  = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      test_word_roundtrip();
      test_subword();
      test_misalign();
      test_mmu_faults();
      test_stall();
      test_no_op();
      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Every op at its worst-case stall plus reset
   initial begin
      #(op_budget * cycles_per_op * 10 + 100);
      $display("Timeout: the tests did not finish in time, %0d errors so far", errors);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== src/lsu_top.sv ====
// Load/store path top level

`timescale 1ns/1ps

module lsu_top (
   input  logic                          clk,
   input  logic                          reset,
   // Operation from execute stage
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic [lsu_pkg::dw-1:0]        operand_1,
   input  logic [lsu_pkg::dw-1:0]        operand_2,
   input  logic [lsu_pkg::dw-1:0]        operand_3,
   input  lsu_pkg::lsu_op_e              op,
   input  logic                          sign_ext,
   input  lsu_pkg::access_size_e         size,
   // Result to writeback
   output logic [lsu_pkg::dw-1:0]        load_data,
   output logic                          exp_taken,
   output logic [lsu_pkg::tgt_w-1:0]     exp_tgt,
   output logic [lsu_pkg::aw-1:0]        lsa,
   output logic                          wb_valid,
   input  logic                          wb_ready
);

   // Fault pulses from checker to unit
   logic dmmu_tlb_miss;
   logic dmmu_page_fault;

   // Unit to checker, checker to RAM
   dbus_if cpu_bus ();
   dbus_if ram_bus ();

   mem_unit u_mem_unit (
      .clk             (clk),
      .reset           (reset),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .operand_1       (operand_1),
      .operand_2       (operand_2),
      .operand_3       (operand_3),
      .op              (op),
      .sign_ext        (sign_ext),
      .size            (size),
      .dmmu_tlb_miss   (dmmu_tlb_miss),
      .dmmu_page_fault (dmmu_page_fault),
      .load_data       (load_data),
      .exp_taken       (exp_taken),
      .exp_tgt         (exp_tgt),
      .lsa             (lsa),
      .wb_valid        (wb_valid),
      .wb_ready        (wb_ready),
      .bus             (cpu_bus)
   );

   dmmu_check u_dmmu_check (
      .clk             (clk),
      .reset           (reset),
      .up              (cpu_bus),
      .down            (ram_bus),
      .dmmu_tlb_miss   (dmmu_tlb_miss),
      .dmmu_page_fault (dmmu_page_fault)
   );

   data_ram u_data_ram (
      .clk   (clk),
      .reset (reset),
      .bus   (ram_bus)
   );

endmodule

// ==== src/data_ram.sv ====
// Word-organized data RAM

`timescale 1ns/1ps

module data_ram (
   input  logic   clk,
   input  logic   reset,
   dbus_if.target bus
);

   logic [lsu_pkg::dw-1:0]     mem [lsu_pkg::ram_words];
   logic [lsu_pkg::ram_aw-1:0] word_addr;
   logic [lsu_pkg::dw-1:0]     dout_q;
   logic                       rsp_valid_q;
   logic                       cmd_hs;

   // Byte address to word index
   assign word_addr = bus.cmd_addr[lsu_pkg::ram_aw+1:2];

   // Free when nothing is held or the held response leaves now
   assign bus.cmd_ready = ~rsp_valid_q | bus.rsp_ready;
   assign cmd_hs        = bus.cmd_valid & bus.cmd_ready;

   // Storage and read data
   always_ff @(posedge clk) begin
      if (cmd_hs) begin
         // Read returns the word as it was before the write
         dout_q <= mem[word_addr];
         for (int b = 0; b < lsu_pkg::msk_w; b++) begin
            if (bus.cmd_we_msk[b]) begin
               mem[word_addr][8*b +: 8] <= bus.din[8*b +: 8];
            end
         end
      end
   end

   // Response valid, held until taken
   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid_q <= 1'b0;
      end else if (cmd_hs) begin
         rsp_valid_q <= 1'b1;
      end else if (bus.rsp_ready) begin
         rsp_valid_q <= 1'b0;
      end
   end

   assign bus.rsp_valid = rsp_valid_q;
   assign bus.dout      = dout_q;

   // Stalled response keeps its data
   assert property (@(posedge clk) disable iff (reset)
      (bus.rsp_valid && !bus.rsp_ready) |=> $stable(bus.dout));

endmodule

// ==== src/dmmu_check.sv ====
// Data MMU address checker

`timescale 1ns/1ps

module dmmu_check (
   input  logic      clk,
   input  logic      reset,
   // Commands from the memory unit
   dbus_if.target    up,
   // Commands toward the RAM
   dbus_if.initiator down,
   // One-cycle fault pulses
   output logic      dmmu_tlb_miss,
   output logic      dmmu_page_fault
);

   logic is_store;
   logic tlb_miss_c;
   logic page_fault_c;
   logic fault_c;

   assign is_store = |up.cmd_we_msk;

   // Anything past the end of RAM has no mapping
   assign tlb_miss_c = up.cmd_valid &
                       (up.cmd_addr >= lsu_pkg::ram_words * lsu_pkg::msk_w);

   // Low page is read-only
   assign page_fault_c = up.cmd_valid & ~tlb_miss_c & is_store &
                         (up.cmd_addr < lsu_pkg::ro_page_limit);

   assign fault_c = tlb_miss_c | page_fault_c;

   // Legal commands pass straight through
   assign down.cmd_valid  = up.cmd_valid & ~fault_c;
   assign down.cmd_addr   = up.cmd_addr;
   assign down.cmd_we_msk = up.cmd_we_msk;
   assign down.din        = up.din;

   // Faulting commands are swallowed at once
   assign up.cmd_ready = fault_c | down.cmd_ready;

   // Response path is combinational
   assign up.rsp_valid    = down.rsp_valid;
   assign up.dout         = down.dout;
   assign down.rsp_ready  = up.rsp_ready;

   // Fault shows up the cycle after acceptance
   always_ff @(posedge clk) begin
      if (reset) begin
         dmmu_tlb_miss   <= 1'b0;
         dmmu_page_fault <= 1'b0;
      end else begin
         dmmu_tlb_miss   <= tlb_miss_c;
         dmmu_page_fault <= page_fault_c;
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      !(dmmu_tlb_miss && dmmu_page_fault));

endmodule

// ==== src/mem_unit.sv ====
// Load/store memory unit

`timescale 1ns/1ps

module mem_unit (
   input  logic                          clk,
   input  logic                          reset,
   // Operation from execute stage
   input  logic                          in_valid,
   output logic                          in_ready,
   input  logic [lsu_pkg::dw-1:0]        operand_1,
   input  logic [lsu_pkg::dw-1:0]        operand_2,
   input  logic [lsu_pkg::dw-1:0]        operand_3,
   input  lsu_pkg::lsu_op_e              op,
   input  logic                          sign_ext,
   input  lsu_pkg::access_size_e         size,
   // Fault pulses from the data MMU
   input  logic                          dmmu_tlb_miss,
   input  logic                          dmmu_page_fault,
   // Result to writeback
   output logic [lsu_pkg::dw-1:0]        load_data,
   output logic                          exp_taken,
   output logic [lsu_pkg::tgt_w-1:0]     exp_tgt,
   output logic [lsu_pkg::aw-1:0]        lsa,
   output logic                          wb_valid,
   input  logic                          wb_ready,
   // Data bus
   dbus_if.initiator                     bus
);

   logic                          is_load;
   logic                          is_store;
   logic                          vld_op;
   logic                          misalign;
   logic                          mmu_fault;
   logic                          pending;
   logic                          cmd_hs;
   logic                          wb_hs;
   logic [1:0]                    lane;
   logic [lsu_pkg::msk_w-1:0]     size_msk;
   logic [lsu_pkg::dw-1:0]        store_data;
   logic [7:0]                    dout_8b;
   logic [15:0]                   dout_16b;
   logic [lsu_pkg::vect_dw-1:0]   exp_vector;

   assign is_load  = (op == lsu_pkg::op_load);
   assign is_store = (op == lsu_pkg::op_store);
   assign vld_op   = in_valid & (is_load | is_store);

   // Effective address
   assign lsa  = operand_1 + operand_2;
   assign lane = lsa[1:0];

   // Halfword needs even address, word needs low bits clear
   assign misalign = vld_op &
                     (((size == lsu_pkg::size_word) & (|lsa[1:0])) |
                      ((size == lsu_pkg::size_half) & lsa[0]));

   // Byte lanes touched by the access
   always_comb begin
      case (size)
         lsu_pkg::size_byte: size_msk = 4'b0001 << lane;
         lsu_pkg::size_half: size_msk = lane[1] ? 4'b1100 : 4'b0011;
         lsu_pkg::size_word: size_msk = 4'b1111;
         default:            size_msk = 4'b0000;
      endcase
   end

   // Replicate store data across all lanes, mask picks the right one
   always_comb begin
      case (size)
         lsu_pkg::size_byte: store_data = {4{operand_3[7:0]}};
         lsu_pkg::size_half: store_data = {2{operand_3[15:0]}};
         default:            store_data = operand_3;
      endcase
   end

   // Command goes out only when idle and aligned
   assign bus.cmd_valid  = vld_op & ~pending & ~misalign;
   assign bus.cmd_addr   = lsa;
   assign bus.cmd_we_msk = is_store ? size_msk : '0;
   assign bus.din        = store_data;

   // Response lane selection from the held address
   always_comb begin
      case (lane)
         2'd0:    dout_8b = bus.dout[7:0];
         2'd1:    dout_8b = bus.dout[15:8];
         2'd2:    dout_8b = bus.dout[23:16];
         default: dout_8b = bus.dout[31:24];
      endcase
   end
   assign dout_16b = lane[1] ? bus.dout[31:16] : bus.dout[15:0];

   // Zero or sign extension
   always_comb begin
      case (size)
         lsu_pkg::size_byte: load_data = {{24{sign_ext & dout_8b[7]}}, dout_8b};
         lsu_pkg::size_half: load_data = {{16{sign_ext & dout_16b[15]}}, dout_16b};
         default:            load_data = bus.dout;
      endcase
   end

   // Writeback follows the bus response directly
   assign wb_valid      = bus.rsp_valid;
   assign bus.rsp_ready = wb_ready;

   assign cmd_hs    = bus.cmd_valid & bus.cmd_ready;
   assign wb_hs     = wb_valid & wb_ready;
   assign mmu_fault = dmmu_tlb_miss | dmmu_page_fault;

   // Busy from command acceptance until result or MMU fault
   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
      end else if (cmd_hs) begin
         pending <= 1'b1;
      end else if (wb_hs | mmu_fault) begin
         pending <= 1'b0;
      end
   end

   // Misalignment is immediate, MMU faults only count while pending
   assign exp_taken = misalign | (pending & mmu_fault);

   always_comb begin
      if (misalign) begin
         exp_vector = lsu_pkg::ealign_vector;
      end else if (dmmu_tlb_miss) begin
         exp_vector = lsu_pkg::edtm_vector;
      end else if (dmmu_page_fault) begin
         exp_vector = lsu_pkg::edpf_vector;
      end else begin
         exp_vector = '0;
      end
   end

   // Vector without its low two bits, zero-extended
   assign exp_tgt = {{(lsu_pkg::tgt_w - lsu_pkg::vect_dw + 2){1'b0}},
                     exp_vector[lsu_pkg::vect_dw-1:2]};

   // Operands may change once the result or exception is delivered
   assign in_ready = ~(is_load | is_store) | wb_hs | exp_taken;

   // MMU never reports both faults for one command
   assert property (@(posedge clk) disable iff (reset)
      !(dmmu_tlb_miss && dmmu_page_fault));

   // No second command while one is outstanding
   assert property (@(posedge clk) disable iff (reset)
      pending |-> !bus.cmd_valid);

endmodule

// ==== src/dbus_if.sv ====
// Data bus interface

`timescale 1ns/1ps

interface dbus_if;

   // Command channel, initiator to target
   logic                       cmd_valid;
   logic                       cmd_ready;
   logic [lsu_pkg::aw-1:0]     cmd_addr;
   // All zero means a load
   logic [lsu_pkg::msk_w-1:0]  cmd_we_msk;
   logic [lsu_pkg::dw-1:0]     din;

   // Response channel, target to initiator
   logic                       rsp_valid;
   logic                       rsp_ready;
   logic [lsu_pkg::dw-1:0]     dout;

   // Side issuing commands
   modport initiator (
      output cmd_valid, cmd_addr, cmd_we_msk, din, rsp_ready,
      input  cmd_ready, rsp_valid, dout
   );

   // Side answering commands
   modport target (
      input  cmd_valid, cmd_addr, cmd_we_msk, din, rsp_ready,
      output cmd_ready, rsp_valid, dout
   );

   // Passive observer
   modport monitor (
      input cmd_valid, cmd_ready, cmd_addr, cmd_we_msk, din,
      input rsp_valid, rsp_ready, dout
   );

endinterface

// ==== src/lsu_pkg.sv ====
// Load/store unit definitions

package lsu_pkg;

   // Datapath widths
   localparam int dw      = 32;
   localparam int aw      = 32;
   localparam int vect_dw = 8;

   // Derived widths
   // One write-enable bit per byte lane
   localparam int msk_w = dw / 8;
   // Exception target drops the two low vector bits
   localparam int tgt_w = aw - 2;

   // Exception vectors
   localparam logic [vect_dw-1:0] ealign_vector = 8'h14;
   localparam logic [vect_dw-1:0] edtm_vector   = 8'h18;
   localparam logic [vect_dw-1:0] edpf_vector   = 8'h1C;

   // Data RAM geometry, 4 KiB
   localparam int ram_words = 1024;
   localparam int ram_aw    = 10;

   // Byte addresses below this are read-only
   localparam logic [aw-1:0] ro_page_limit = 'h100;

   // Operation issued by the execute stage
   typedef enum logic [1:0] {
      op_none  = 2'd0,
      op_load  = 2'd1,
      op_store = 2'd2
   } lsu_op_e;

   // Access size, encoded as in the instruction decoder
   typedef enum logic [2:0] {
      size_byte = 3'd1,
      size_half = 3'd2,
      size_word = 3'd3
   } access_size_e;

endpackage
